// ==== Bender.yml ====
package:
  name: rs_station

sources:
  - files:
      - design/rs_pkg.sv
      - design/rs_entry_array.sv
      - design/rs_slot_alloc.sv
      - design/rs_issue_select.sv
      - design/rs_top.sv
  - target: test
    files:
      - tb/rs_chk.sv
      - tb/rs_tb.sv

// ==== design/rs_entry_array.sv ====
`timescale 1ns/1ns

module rs_entry_array #(
    parameter int DEPTH = 8,
    parameter int WIDTH = 2
) (
    input  logic                          clock,
    input  logic                          reset,
    input  rs_pkg::dispatch_t [WIDTH-1:0] dispatch,
    input  logic [WIDTH-1:0][DEPTH-1:0]   alloc_gnt,
    input  rs_pkg::cdb_t [WIDTH-1:0]      cdb,
    input  rs_pkg::br_task_e              br_task,
    input  rs_pkg::br_mask_t              rem_b_id,
    input  logic [DEPTH-1:0]              release_vec,
    output rs_pkg::rs_entry_t [DEPTH-1:0] entries
);
    import rs_pkg::*;

    rs_entry_t [DEPTH-1:0] entry_q;
    rs_entry_t [DEPTH-1:0] entry_d;
    logic [DEPTH-1:0]      valid_q;
    logic [DEPTH-1:0]      valid_d;

    // Branches dispatched and not yet resolved
    br_mask_t mask_q;
    br_mask_t mask_d;
    br_mask_t lane_mask;
    logic     resolve;

    // Ready as soon as any valid CDB lane carries the tag
    function automatic src_tag_t wake(input src_tag_t src, input cdb_t [WIDTH-1:0] bus);
        src_tag_t woken;
        woken = src;
        for (int l = 0; l < WIDTH; l++) begin
            if (bus[l].valid && bus[l].preg == src.idx) begin
                woken.ready = 1'b1;
            end
        end
        return woken;
    endfunction

    assign resolve = (br_task != NONE);

    always_comb begin
        entry_d = entry_q;
        valid_d = valid_q;

        for (int i = 0; i < DEPTH; i++) begin
            entry_d[i].inst.src1 = wake(entry_q[i].inst.src1, cdb);
            entry_d[i].inst.src2 = wake(entry_q[i].inst.src2, cdb);

            if (br_task == CLEAR) begin
                entry_d[i].b_mask = entry_q[i].b_mask & ~rem_b_id;
            end
            // Mispredicted branch kills everything that depends on it
            if (br_task == SQUASH && (entry_q[i].b_mask & rem_b_id) != '0) begin
                valid_d[i] = 1'b0;
            end
            if (release_vec[i]) begin
                valid_d[i] = 1'b0;
            end
        end

        // A lane inherits the branches of older lanes in the same cycle
        lane_mask = mask_q;
        for (int l = 0; l < WIDTH; l++) begin
            for (int j = 0; j < DEPTH; j++) begin
                if (dispatch[l].valid && alloc_gnt[l][j]) begin
                    entry_d[j].inst      = dispatch[l];
                    entry_d[j].inst.src1 = wake(dispatch[l].src1, cdb);
                    entry_d[j].inst.src2 = wake(dispatch[l].src2, cdb);
                    entry_d[j].b_mask    = resolve ? (lane_mask & ~rem_b_id) : lane_mask;
                    valid_d[j]           = 1'b1;
                end
            end
            if (dispatch[l].valid) begin
                lane_mask = lane_mask | dispatch[l].b_id;
            end
        end

        mask_d = resolve ? (lane_mask & ~rem_b_id) : lane_mask;
    end

    always_ff @(posedge clock) begin
        entry_q <= entry_d;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
            mask_q  <= '0;
        end else begin
            valid_q <= valid_d;
            mask_q  <= mask_d;
        end
    end

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            entries[i]            = entry_q[i];
            entries[i].inst.valid = valid_q[i];
        end
    end

endmodule

// ==== design/rs_issue_select.sv ====
`timescale 1ns/1ns

module rs_issue_select #(
    parameter int                DEPTH    = 8,
    parameter int                NUM_FU   = 2,
    parameter rs_pkg::fu_class_e FU_CLASS = rs_pkg::ALU_INST
) (
    input  rs_pkg::rs_entry_t [DEPTH-1:0] entries,
    input  logic [NUM_FU-1:0]             fu_busy,
    input  rs_pkg::br_task_e              br_task,
    input  rs_pkg::br_mask_t              rem_b_id,
    output rs_pkg::issue_t [NUM_FU-1:0]   issued,
    output logic [DEPTH-1:0]              release_vec
);
    import rs_pkg::*;

    logic [DEPTH-1:0] req;
    logic [DEPTH-1:0] pending;
    logic             found;

    // Packet as seen by the unit, with a branch resolving this very cycle applied
    function automatic issue_t make_issue(input rs_entry_t e, input br_task_e bt,
                                          input br_mask_t rem);
        issue_t pkt;
        pkt.valid    = e.inst.valid;
        pkt.fu_class = e.inst.fu_class;
        pkt.opcode   = e.inst.opcode;
        pkt.dest     = e.inst.dest;
        pkt.src1     = e.inst.src1.idx;
        pkt.src2     = e.inst.src2.idx;
        pkt.b_mask   = e.b_mask;
        if (bt == SQUASH && (e.b_mask & rem) != '0) begin
            pkt.valid = 1'b0;
        end
        if (bt == CLEAR) begin
            pkt.b_mask = e.b_mask & ~rem;
        end
        return pkt;
    endfunction

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            req[i] = entries[i].inst.valid
                  && entries[i].inst.fu_class == FU_CLASS
                  && entries[i].inst.src1.ready
                  && entries[i].inst.src2.ready;
        end
    end

    // Lowest ready entry goes to the lowest free unit
    always_comb begin
        pending     = req;
        issued      = '0;
        release_vec = '0;
        found       = 1'b0;
        for (int u = 0; u < NUM_FU; u++) begin
            // A busy unit takes nothing this cycle
            found = fu_busy[u];
            for (int j = 0; j < DEPTH; j++) begin
                if (pending[j] && !found) begin
                    found          = 1'b1;
                    pending[j]     = 1'b0;
                    release_vec[j] = 1'b1;
                    issued[u]      = make_issue(entries[j], br_task, rem_b_id);
                end
            end
        end
    end

endmodule

// ==== design/rs_pkg.sv ====
package rs_pkg;

    // Default sizing, overridden through the top level parameters
    localparam int RS_DEPTH       = 8;
    localparam int DISPATCH_WIDTH = 2;
    localparam int NUM_ALU        = 2;
    localparam int NUM_MULT       = 1;
    localparam int NUM_BR         = 1;

    localparam int PREG_BITS = 6;
    localparam int BR_BITS   = 4;

    typedef logic [PREG_BITS-1:0] preg_t;

    // One bit per unresolved branch, tags are one-hot
    typedef logic [BR_BITS-1:0] br_mask_t;

    typedef enum logic [1:0] {
        ALU_INST  = 2'd0,
        MULT_INST = 2'd1,
        BR_INST   = 2'd2
    } fu_class_e;

    typedef enum logic [1:0] {
        NONE   = 2'd0,
        CLEAR  = 2'd1,
        SQUASH = 2'd2
    } br_task_e;

    typedef struct packed {
        preg_t idx;
        logic  ready;
    } src_tag_t;

    // b_id is the branch tag of this instruction itself, zero if not a branch
    typedef struct packed {
        logic      valid;
        fu_class_e fu_class;
        logic [7:0] opcode;
        preg_t     dest;
        src_tag_t  src1;
        src_tag_t  src2;
        br_mask_t  b_id;
    } dispatch_t;

    typedef struct packed {
        logic  valid;
        preg_t preg;
    } cdb_t;

    typedef struct packed {
        dispatch_t inst;
        br_mask_t  b_mask;
    } rs_entry_t;

    typedef struct packed {
        logic       valid;
        fu_class_e  fu_class;
        logic [7:0] opcode;
        preg_t      dest;
        preg_t      src1;
        preg_t      src2;
        br_mask_t   b_mask;
    } issue_t;

endpackage

// ==== design/rs_slot_alloc.sv ====
`timescale 1ns/1ns

module rs_slot_alloc #(
    parameter int DEPTH = 8,
    parameter int WIDTH = 2
) (
    input  rs_pkg::rs_entry_t [DEPTH-1:0] entries,
    output logic [WIDTH-1:0][DEPTH-1:0]   alloc_gnt,
    output logic [$clog2(WIDTH+1)-1:0]    open_entries
);
    localparam int CNT_BITS  = $clog2(DEPTH + 1);
    localparam int OPEN_BITS = $clog2(WIDTH + 1);

    logic [DEPTH-1:0]    free_vec;
    logic [DEPTH-1:0]    avail;
    logic [CNT_BITS-1:0] free_cnt;
    logic                taken;

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            free_vec[i] = ~entries[i].inst.valid;
        end
    end

    // Lane 0 gets the lowest free entry, lane 1 the next one and so on
    always_comb begin
        avail     = free_vec;
        alloc_gnt = '0;
        taken     = 1'b0;
        for (int l = 0; l < WIDTH; l++) begin
            taken = 1'b0;
            for (int j = 0; j < DEPTH; j++) begin
                if (avail[j] && !taken) begin
                    alloc_gnt[l][j] = 1'b1;
                    avail[j]        = 1'b0;
                    taken           = 1'b1;
                end
            end
        end
    end

    always_comb begin
        free_cnt = '0;
        for (int i = 0; i < DEPTH; i++) begin
            free_cnt = free_cnt + CNT_BITS'(free_vec[i]);
        end
    end

    assign open_entries = (free_cnt > CNT_BITS'(WIDTH)) ? OPEN_BITS'(WIDTH)
                                                         : OPEN_BITS'(free_cnt);

endmodule

// ==== design/rs_top.sv ====
`timescale 1ns/1ns

module rs_top #(
    parameter int DEPTH    = rs_pkg::RS_DEPTH,
    parameter int WIDTH    = rs_pkg::DISPATCH_WIDTH,
    parameter int NUM_ALU  = rs_pkg::NUM_ALU,
    parameter int NUM_MULT = rs_pkg::NUM_MULT,
    parameter int NUM_BR   = rs_pkg::NUM_BR
) (
    input  logic                            clock,
    input  logic                            reset,
    input  rs_pkg::dispatch_t [WIDTH-1:0]   dispatch,
    input  rs_pkg::cdb_t [WIDTH-1:0]        cdb,
    input  rs_pkg::br_task_e                br_task,
    input  rs_pkg::br_mask_t                rem_b_id,
    input  logic [NUM_ALU-1:0]              alu_busy,
    input  logic [NUM_MULT-1:0]             mult_busy,
    input  logic [NUM_BR-1:0]               br_busy,
    output rs_pkg::issue_t [NUM_ALU-1:0]    issued_alu,
    output rs_pkg::issue_t [NUM_MULT-1:0]   issued_mult,
    output rs_pkg::issue_t [NUM_BR-1:0]     issued_br,
    output logic [$clog2(WIDTH+1)-1:0]      open_entries
);
    import rs_pkg::*;

    rs_entry_t [DEPTH-1:0]       entries;
    logic [WIDTH-1:0][DEPTH-1:0] alloc_gnt;
    logic [DEPTH-1:0]            alu_rel;
    logic [DEPTH-1:0]            mult_rel;
    logic [DEPTH-1:0]            br_rel;
    logic [DEPTH-1:0]            release_vec;

    // Each entry belongs to one class, so the release vectors never overlap
    assign release_vec = alu_rel | mult_rel | br_rel;

    rs_entry_array #(.DEPTH(DEPTH), .WIDTH(WIDTH)) entry_array (
        .clock      (clock),
        .reset      (reset),
        .dispatch   (dispatch),
        .alloc_gnt  (alloc_gnt),
        .cdb        (cdb),
        .br_task    (br_task),
        .rem_b_id   (rem_b_id),
        .release_vec(release_vec),
        .entries    (entries)
    );

    rs_slot_alloc #(.DEPTH(DEPTH), .WIDTH(WIDTH)) slot_alloc (
        .entries     (entries),
        .alloc_gnt   (alloc_gnt),
        .open_entries(open_entries)
    );

    rs_issue_select #(.DEPTH(DEPTH), .NUM_FU(NUM_ALU), .FU_CLASS(ALU_INST)) alu_sel (
        .entries    (entries),
        .fu_busy    (alu_busy),
        .br_task    (br_task),
        .rem_b_id   (rem_b_id),
        .issued     (issued_alu),
        .release_vec(alu_rel)
    );

    rs_issue_select #(.DEPTH(DEPTH), .NUM_FU(NUM_MULT), .FU_CLASS(MULT_INST)) mult_sel (
        .entries    (entries),
        .fu_busy    (mult_busy),
        .br_task    (br_task),
        .rem_b_id   (rem_b_id),
        .issued     (issued_mult),
        .release_vec(mult_rel)
    );

    rs_issue_select #(.DEPTH(DEPTH), .NUM_FU(NUM_BR), .FU_CLASS(BR_INST)) br_sel (
        .entries    (entries),
        .fu_busy    (br_busy),
        .br_task    (br_task),
        .rem_b_id   (rem_b_id),
        .issued     (issued_br),
        .release_vec(br_rel)
    );

endmodule

// ==== flist.f ====
design/rs_pkg.sv
design/rs_entry_array.sv
design/rs_slot_alloc.sv
design/rs_issue_select.sv
design/rs_top.sv
tb/rs_chk.sv
tb/rs_tb.sv

// ==== tb/rs_chk.sv ====
`timescale 1ns/1ns

module rs_chk #(
    parameter int WIDTH    = 2,
    parameter int NUM_ALU  = 2,
    parameter int NUM_MULT = 1,
    parameter int NUM_BR   = 1
) (
    input logic                          clock,
    input logic                          reset,
    input rs_pkg::dispatch_t [WIDTH-1:0] dispatch,
    input rs_pkg::issue_t [NUM_ALU-1:0]  issued_alu,
    input rs_pkg::issue_t [NUM_MULT-1:0] issued_mult,
    input rs_pkg::issue_t [NUM_BR-1:0]   issued_br,
    input logic [$clog2(WIDTH+1)-1:0]    open_entries
);
    import rs_pkg::*;

    localparam int NUM_OUT = NUM_ALU + NUM_MULT + NUM_BR;

    issue_t [NUM_OUT-1:0] all_issued;
    logic                 any_valid;
    logic                 dest_clash;
    logic                 excess;
    int                   fail_count = 0;

    assign all_issued = {issued_br, issued_mult, issued_alu};

    always_comb begin
        any_valid  = 1'b0;
        dest_clash = 1'b0;
        excess     = 1'b0;
        for (int i = 0; i < NUM_OUT; i++) begin
            any_valid = any_valid | all_issued[i].valid;
            for (int j = i + 1; j < NUM_OUT; j++) begin
                if (all_issued[i].valid && all_issued[j].valid
                        && all_issued[i].dest == all_issued[j].dest) begin
                    dest_clash = 1'b1;
                end
            end
        end
        for (int l = 0; l < WIDTH; l++) begin
            if (dispatch[l].valid && l >= open_entries) begin
                excess = 1'b1;
            end
        end
    end

    assert property (@(posedge clock) reset && $past(reset) |-> !any_valid)
        else begin
            $error("an issue valid is high during reset");
            fail_count++;
        end

    assert property (@(posedge clock) disable iff (reset) !dest_clash)
        else begin
            $error("two issued packets carry the same dest");
            fail_count++;
        end

    assert property (@(posedge clock) disable iff (reset) !excess)
        else begin
            $error("a dispatch lane beyond open_entries is valid");
            fail_count++;
        end

endmodule

bind rs_top rs_chk #(
    .WIDTH   (WIDTH),
    .NUM_ALU (NUM_ALU),
    .NUM_MULT(NUM_MULT),
    .NUM_BR  (NUM_BR)
) chk (.*);

// ==== tb/rs_tb.sv ====
`timescale 1ns/1ns

module rs_tb;
    import rs_pkg::*;

    typedef logic [$clog2(DISPATCH_WIDTH+1)-1:0] open_t;

    logic                               clock;
    logic                               reset;
    dispatch_t [DISPATCH_WIDTH-1:0]     dispatch;
    cdb_t [DISPATCH_WIDTH-1:0]          cdb;
    br_task_e                           br_task;
    br_mask_t                           rem_b_id;
    logic [NUM_ALU-1:0]                 alu_busy;
    logic [NUM_MULT-1:0]                mult_busy;
    logic [NUM_BR-1:0]                  br_busy;
    issue_t [NUM_ALU-1:0]               issued_alu;
    issue_t [NUM_MULT-1:0]              issued_mult;
    issue_t [NUM_BR-1:0]                issued_br;
    open_t                              open_entries;

    int          errors;
    logic [31:0] seed;
    preg_t       next_dest;

    rs_top UUT (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic logic [31:0] random_word();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Dest tags count up so no two packets in flight share one
    function automatic dispatch_t new_inst(input fu_class_e cls, input logic rdy1,
                                           input logic rdy2, input br_mask_t bid);
        dispatch_t   d;
        logic [31:0] r;
        r = random_word();
        d.valid      = 1'b1;
        d.fu_class   = cls;
        d.opcode     = r[31:24];
        d.dest       = next_dest;
        d.src1.idx   = r[21:16];
        d.src1.ready = rdy1;
        d.src2.idx   = r[13:8];
        d.src2.ready = rdy2;
        d.b_id       = bid;
        next_dest    = next_dest + 1'b1;
        return d;
    endfunction

    function automatic issue_t expected_packet(input dispatch_t d, input br_mask_t mask);
        issue_t p;
        p.valid    = 1'b1;
        p.fu_class = d.fu_class;
        p.opcode   = d.opcode;
        p.dest     = d.dest;
        p.src1     = d.src1.idx;
        p.src2     = d.src2.idx;
        p.b_mask   = mask;
        return p;
    endfunction

    // Fields of an invalid packet carry no meaning
    task automatic check_issue(input string name, input issue_t expected, input issue_t actual);
        if (expected.valid ? (actual !== expected) : (actual.valid !== 1'b0)) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_open(input string name, input open_t expected, input open_t actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_idle(input string name);
        for (int u = 0; u < NUM_ALU; u++) begin
            check_issue(name, '0, issued_alu[u]);
        end
        check_issue(name, '0, issued_mult[0]);
        check_issue(name, '0, issued_br[0]);
    endtask

    // Inputs change 1 ns after the edge and return to idle unless a test sets them
    task automatic next_cycle();
        @(posedge clock);
        #1;
        dispatch = '0;
        cdb      = '0;
        br_task  = NONE;
        rem_b_id = '0;
    endtask

    task automatic after_reset();
        #1;
        check_open("after reset", 2, open_entries);
        check_idle("after reset");
    endtask

    task automatic ready_alu_pair();
        dispatch_t a;
        dispatch_t b;
        next_cycle();
        a = new_inst(ALU_INST, 1'b1, 1'b1, '0);
        b = new_inst(ALU_INST, 1'b1, 1'b1, '0);
        dispatch[0] = a;
        dispatch[1] = b;
        next_cycle();
        #1;
        check_issue("alu pair lane 0", expected_packet(a, '0), issued_alu[0]);
        check_issue("alu pair lane 1", expected_packet(b, '0), issued_alu[1]);
        next_cycle();
        #1;
        check_idle("alu pair released");
        check_open("alu pair released", 2, open_entries);
    endtask

    task automatic cdb_wakeup();
        dispatch_t m;
        next_cycle();
        m = new_inst(MULT_INST, 1'b0, 1'b1, '0);
        dispatch[0] = m;
        next_cycle();
        #1;
        check_issue("cdb before wakeup", '0, issued_mult[0]);
        next_cycle();
        cdb[0].valid = 1'b1;
        cdb[0].preg  = m.src1.idx;
        #1;
        check_issue("cdb broadcast cycle", '0, issued_mult[0]);
        next_cycle();
        #1;
        check_issue("cdb wakeup", expected_packet(m, '0), issued_mult[0]);
        next_cycle();
        #1;
        check_idle("cdb after issue");
    endtask

    task automatic alu_backpressure();
        dispatch_t q[8];
        for (int k = 0; k < 4; k++) begin
            next_cycle();
            alu_busy    = '1;
            q[2*k]      = new_inst(ALU_INST, 1'b1, 1'b1, '0);
            q[2*k+1]    = new_inst(ALU_INST, 1'b1, 1'b1, '0);
            dispatch[0] = q[2*k];
            dispatch[1] = q[2*k+1];
            #1;
            check_open("backpressure filling", 2, open_entries);
            check_idle("backpressure filling");
        end
        next_cycle();
        #1;
        check_open("backpressure full", 0, open_entries);
        check_idle("backpressure full");
        for (int k = 0; k < 4; k++) begin
            next_cycle();
            alu_busy = '0;
            #1;
            check_issue("backpressure drain 0", expected_packet(q[2*k], '0), issued_alu[0]);
            check_issue("backpressure drain 1", expected_packet(q[2*k+1], '0), issued_alu[1]);
        end
        next_cycle();
        #1;
        check_open("backpressure empty", 2, open_entries);
        check_idle("backpressure empty");
    endtask

    // Branch with tag 1 on lane 0, one dependent beside it and one a cycle later
    task automatic branch_setup(output dispatch_t d1, output dispatch_t d2);
        dispatch_t br;
        next_cycle();
        alu_busy    = '1;
        br          = new_inst(BR_INST, 1'b1, 1'b1, 4'b0001);
        d1          = new_inst(ALU_INST, 1'b1, 1'b1, '0);
        dispatch[0] = br;
        dispatch[1] = d1;
        next_cycle();
        d2          = new_inst(ALU_INST, 1'b1, 1'b1, '0);
        dispatch[0] = d2;
        #1;
        check_issue("branch issue", expected_packet(br, '0), issued_br[0]);
        check_issue("branch dependents held", '0, issued_alu[0]);
    endtask

    task automatic branch_squash();
        dispatch_t d1;
        dispatch_t d2;
        branch_setup(d1, d2);
        // Later dependents fill the station
        for (int k = 0; k < 3; k++) begin
            next_cycle();
            dispatch[0] = new_inst(ALU_INST, 1'b1, 1'b1, '0);
            dispatch[1] = new_inst(ALU_INST, 1'b1, 1'b1, '0);
        end
        next_cycle();
        br_task  = SQUASH;
        rem_b_id = 4'b0001;
        alu_busy = 2'b10;
        #1;
        check_open("squash station full", 0, open_entries);
        check_issue("squash cycle lane 0", '0, issued_alu[0]);
        check_issue("squash cycle lane 1", '0, issued_alu[1]);
        next_cycle();
        alu_busy = '0;
        #1;
        check_open("squash recovery", 2, open_entries);
        check_idle("squash dependents gone");
        next_cycle();
        #1;
        check_idle("squash dependents gone");
    endtask

    task automatic branch_clear();
        dispatch_t d1;
        dispatch_t d2;
        branch_setup(d1, d2);
        next_cycle();
        br_task  = CLEAR;
        rem_b_id = 4'b0001;
        alu_busy = 2'b10;
        #1;
        check_issue("clear cycle", expected_packet(d1, '0), issued_alu[0]);
        check_issue("clear cycle busy unit", '0, issued_alu[1]);
        next_cycle();
        alu_busy = '0;
        #1;
        check_issue("after clear", expected_packet(d2, '0), issued_alu[0]);
        next_cycle();
        #1;
        check_open("clear drained", 2, open_entries);
        check_idle("clear drained");
    endtask

    initial begin
        errors    = 0;
        seed      = 32'h2453_e0de;
        next_dest = '0;
        reset     = 1'b1;
        dispatch  = '0;
        cdb       = '0;
        br_task   = NONE;
        rem_b_id  = '0;
        alu_busy  = '0;
        mult_busy = '0;
        br_busy   = '0;
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;
        after_reset();
        ready_alu_pair();
        cdb_wakeup();
        alu_backpressure();
        branch_squash();
        branch_clear();
        $display("check errors: %0d, assertion errors: %0d", errors, UUT.chk.fail_count);
        if (errors == 0 && UUT.chk.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
